// File: src/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

	// Word size for data, addresses and instructions
	localparam int XLEN = 32;

	// ====================
	// Major opcodes

	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;

	// ====================
	// Function codes

	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_OR  = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;

	// Only full-word accesses exist
	localparam logic [2:0] F3_W = 3'b010;

	localparam logic [6:0] F7_SUB = 7'b0100000;

	localparam logic [XLEN-1:0] RESET_PC = '0;

endpackage

`default_nettype wire

// File: src/cpu_pipe_pkg.sv
`default_nettype none

package cpu_pipe_pkg;

	// Register index width, x0 to x31
	localparam int REG_INDEX_WIDTH = 5;

	// ====================
	// ALU function select

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B
	} alu_op_t;

	// ====================
	// Instruction class seen by execute

	typedef enum logic [1:0] {
		KIND_ALU,
		KIND_BRANCH,
		KIND_JAL,
		KIND_MEM
	} op_kind_t;

endpackage

`default_nettype wire

// File: src/cpu_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_fetch (
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_stall,
	input  logic i_redirect,
	input  logic [cpu_isa_pkg::XLEN-1:0] i_target,
	input  logic [cpu_isa_pkg::XLEN-1:0] i_ibus_dat,
	input  logic i_ibus_ack,
	output logic o_ibus_cyc,
	output logic o_ibus_stb,
	output logic [cpu_isa_pkg::XLEN-1:0] o_ibus_adr,
	output logic o_valid,
	output logic [cpu_isa_pkg::XLEN-1:0] o_instruction,
	output logic [cpu_isa_pkg::XLEN-1:0] o_pc
);
	import cpu_isa_pkg::*;

	logic cyc;
	logic discard;
	logic [XLEN-1:0] pc;
	// Bus address is latched per read and holds until ack
	logic [XLEN-1:0] adr;
	logic load_word;

	assign o_ibus_cyc = cyc;
	assign o_ibus_stb = cyc;
	assign o_ibus_adr = adr;

	// Word lands in the fetch register unless a redirect killed it
	assign load_word = cyc && i_ibus_ack && !discard && !i_redirect;

	// ====================
	// Bus cycle and program counter

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			cyc <= 1'b0;
			discard <= 1'b0;
			pc <= RESET_PC;
			adr <= RESET_PC;
		end else begin
			if (cyc) begin
				if (i_ibus_ack) begin
					cyc <= 1'b0;
					discard <= 1'b0;
				end else if (i_redirect) begin
					// Let the pending read finish, then drop its data
					discard <= 1'b1;
				end
			end else if (i_redirect || !i_stall) begin
				// Fetch register is empty or being consumed
				cyc <= 1'b1;
				adr <= i_redirect ? i_target : pc;
			end
			if (i_redirect) begin
				pc <= i_target;
			end else if (load_word) begin
				pc <= pc + XLEN'(4);
			end
		end
	end

	// ====================
	// Fetch stage register

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_valid <= 1'b0;
		end else if (i_redirect) begin
			o_valid <= 1'b0;
		end else if (load_word) begin
			o_valid <= 1'b1;
		end else if (!i_stall) begin
			o_valid <= 1'b0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (load_word) begin
			o_instruction <= i_ibus_dat;
			o_pc <= pc;
		end
	end

endmodule

`default_nettype wire

// File: src/cpu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_decode (
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_stall,
	input  logic i_flush,
	input  logic i_valid,
	input  logic [cpu_isa_pkg::XLEN-1:0] i_instruction,
	input  logic [cpu_isa_pkg::XLEN-1:0] i_pc,
	output logic o_valid,
	output logic [cpu_isa_pkg::XLEN-1:0] o_pc,
	output logic [cpu_pipe_pkg::REG_INDEX_WIDTH-1:0] o_rs1_idx,
	output logic [cpu_pipe_pkg::REG_INDEX_WIDTH-1:0] o_rs2_idx,
	output logic [cpu_pipe_pkg::REG_INDEX_WIDTH-1:0] o_rd_idx,
	output logic [cpu_isa_pkg::XLEN-1:0] o_imm,
	output cpu_pipe_pkg::op_kind_t o_kind,
	output cpu_pipe_pkg::alu_op_t o_alu_op,
	output logic o_use_imm,
	output logic o_branch_ne,
	output logic o_mem_read,
	output logic o_mem_write,
	output logic o_fault
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	logic [6:0] opcode;
	logic [2:0] f3;
	logic [6:0] f7;
	logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	logic arith_ok;

	logic legal;
	op_kind_t kind;
	alu_op_t alu_op;
	logic use_imm, mem_read, mem_write;
	logic [XLEN-1:0] imm;
	logic [REG_INDEX_WIDTH-1:0] rs1_idx, rs2_idx, rd_idx;

	function automatic alu_op_t alu_from_f3(input logic [2:0] code);
		alu_op_t op;
		case (code)
			F3_SLT: op = ALU_SLT;
			F3_XOR: op = ALU_XOR;
			F3_OR: op = ALU_OR;
			F3_AND: op = ALU_AND;
			default: op = ALU_ADD;
		endcase
		return op;
	endfunction

	// ====================
	// Fields and immediates

	assign opcode = i_instruction[6:0];
	assign f3 = i_instruction[14:12];
	assign f7 = i_instruction[31:25];

	assign imm_i = {{20{i_instruction[31]}}, i_instruction[31:20]};
	assign imm_s = {{20{i_instruction[31]}}, i_instruction[31:25], i_instruction[11:7]};
	assign imm_b = {{19{i_instruction[31]}}, i_instruction[31], i_instruction[7],
		i_instruction[30:25], i_instruction[11:8], 1'b0};
	assign imm_u = {i_instruction[31:12], 12'b0};
	assign imm_j = {{11{i_instruction[31]}}, i_instruction[31], i_instruction[19:12],
		i_instruction[20], i_instruction[30:21], 1'b0};

	assign arith_ok = (f3 == F3_ADD) || (f3 == F3_SLT) || (f3 == F3_XOR) ||
		(f3 == F3_OR) || (f3 == F3_AND);

	// ====================
	// Control decode

	// Unused source indices stay zero so they never cause a load-use stall
	always_comb begin
		legal = 1'b0;
		kind = KIND_ALU;
		alu_op = ALU_ADD;
		use_imm = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		imm = imm_i;
		rs1_idx = '0;
		rs2_idx = '0;
		rd_idx = '0;
		case (opcode)
			OP_LUI: begin
				legal = 1'b1;
				alu_op = ALU_PASS_B;
				use_imm = 1'b1;
				imm = imm_u;
				rd_idx = i_instruction[11:7];
			end
			OP_JAL: begin
				legal = 1'b1;
				kind = KIND_JAL;
				imm = imm_j;
				rd_idx = i_instruction[11:7];
			end
			OP_BRANCH: begin
				legal = (f3 == F3_BEQ) || (f3 == F3_BNE);
				kind = KIND_BRANCH;
				imm = imm_b;
				rs1_idx = i_instruction[19:15];
				rs2_idx = i_instruction[24:20];
			end
			OP_LOAD: begin
				legal = (f3 == F3_W);
				kind = KIND_MEM;
				use_imm = 1'b1;
				mem_read = 1'b1;
				rs1_idx = i_instruction[19:15];
				rd_idx = i_instruction[11:7];
			end
			OP_STORE: begin
				legal = (f3 == F3_W);
				kind = KIND_MEM;
				use_imm = 1'b1;
				mem_write = 1'b1;
				imm = imm_s;
				rs1_idx = i_instruction[19:15];
				rs2_idx = i_instruction[24:20];
			end
			OP_IMM: begin
				legal = arith_ok;
				alu_op = alu_from_f3(f3);
				use_imm = 1'b1;
				rs1_idx = i_instruction[19:15];
				rd_idx = i_instruction[11:7];
			end
			OP_REG: begin
				legal = arith_ok && ((f7 == 7'b0) || (f7 == F7_SUB && f3 == F3_ADD));
				alu_op = (f7 == F7_SUB) ? ALU_SUB : alu_from_f3(f3);
				rs1_idx = i_instruction[19:15];
				rs2_idx = i_instruction[24:20];
				rd_idx = i_instruction[11:7];
			end
			default: begin
				legal = 1'b0;
			end
		endcase
	end

	// ====================
	// Decode stage register

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_valid <= 1'b0;
			o_fault <= 1'b0;
		end else if (i_flush) begin
			o_valid <= 1'b0;
		end else if (!i_stall) begin
			o_valid <= i_valid && legal && !o_fault;
			if (i_valid && !legal) begin
				o_fault <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_stall) begin
			o_pc <= i_pc;
			o_rs1_idx <= rs1_idx;
			o_rs2_idx <= rs2_idx;
			o_rd_idx <= rd_idx;
			o_imm <= imm;
			o_kind <= kind;
			o_alu_op <= alu_op;
			o_use_imm <= use_imm;
			o_branch_ne <= (f3 == F3_BNE);
			o_mem_read <= mem_read;
			o_mem_write <= mem_write;
		end
	end

endmodule

`default_nettype wire

// File: src/cpu_operands.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_operands (
	input  logic i_clock,
	input  logic i_reset,
	input  logic [cpu_pipe_pkg::REG_INDEX_WIDTH-1:0] i_rs1_idx,
	input  logic [cpu_pipe_pkg::REG_INDEX_WIDTH-1:0] i_rs2_idx,
	input  logic i_ex_valid,
	input  logic [cpu_pipe_pkg::REG_INDEX_WIDTH-1:0] i_ex_rd,
	input  logic [cpu_isa_pkg::XLEN-1:0] i_ex_value,
	input  logic i_ex_load,
	input  logic i_mem_valid,
	input  logic [cpu_pipe_pkg::REG_INDEX_WIDTH-1:0] i_mem_rd,
	input  logic [cpu_isa_pkg::XLEN-1:0] i_mem_value,
	input  logic i_wb_valid,
	input  logic [cpu_pipe_pkg::REG_INDEX_WIDTH-1:0] i_wb_rd,
	input  logic [cpu_isa_pkg::XLEN-1:0] i_wb_value,
	output logic [cpu_isa_pkg::XLEN-1:0] o_rs1,
	output logic [cpu_isa_pkg::XLEN-1:0] o_rs2,
	output logic o_load_use_stall
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	// x0 is never stored
	logic [XLEN-1:0] regs [1:31];

	function automatic logic [XLEN-1:0] pick(
		input logic [REG_INDEX_WIDTH-1:0] idx,
		input logic [XLEN-1:0] file_value
	);
		logic [XLEN-1:0] value;
		if (idx == '0) value = '0;
		else if (i_ex_valid && !i_ex_load && i_ex_rd == idx) value = i_ex_value;
		else if (i_mem_valid && i_mem_rd == idx) value = i_mem_value;
		else if (i_wb_valid && i_wb_rd == idx) value = i_wb_value;
		else value = file_value;
		return value;
	endfunction

	always_ff @(posedge i_clock) begin
		if (!i_reset && i_wb_valid && i_wb_rd != '0) begin
			regs[i_wb_rd] <= i_wb_value;
		end
	end

	always_comb begin
		o_rs1 = pick(i_rs1_idx, (i_rs1_idx == '0) ? '0 : regs[i_rs1_idx]);
		o_rs2 = pick(i_rs2_idx, (i_rs2_idx == '0) ? '0 : regs[i_rs2_idx]);
	end

	// Load result is not ready until it reaches the memory register
	assign o_load_use_stall = i_ex_valid && i_ex_load && (i_ex_rd != '0) &&
		((i_ex_rd == i_rs1_idx) || (i_ex_rd == i_rs2_idx));

endmodule

`default_nettype wire

// File: src/cpu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_execute (
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_stall,
	input  logic i_valid,
	input  logic [cpu_isa_pkg::XLEN-1:0] i_pc,
	input  logic [cpu_pipe_pkg::REG_INDEX_WIDTH-1:0] i_rd_idx,
	input  logic [cpu_isa_pkg::XLEN-1:0] i_imm,
	input  cpu_pipe_pkg::op_kind_t i_kind,
	input  cpu_pipe_pkg::alu_op_t i_alu_op,
	input  logic i_use_imm,
	input  logic i_branch_ne,
	input  logic i_mem_read,
	input  logic i_mem_write,
	input  logic [cpu_isa_pkg::XLEN-1:0] i_rs1,
	input  logic [cpu_isa_pkg::XLEN-1:0] i_rs2,
	output logic o_valid,
	output logic [cpu_pipe_pkg::REG_INDEX_WIDTH-1:0] o_rd_idx,
	output logic [cpu_isa_pkg::XLEN-1:0] o_result,
	output logic o_mem_read,
	output logic o_mem_write,
	output logic [cpu_isa_pkg::XLEN-1:0] o_store_data,
	output logic o_redirect,
	output logic [cpu_isa_pkg::XLEN-1:0] o_target
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] alu;
	logic [XLEN-1:0] result;
	logic taken;
	logic in_valid;

	// ====================
	// ALU

	assign op_b = i_use_imm ? i_imm : i_rs2;

	always_comb begin
		case (i_alu_op)
			ALU_ADD: alu = i_rs1 + op_b;
			ALU_SUB: alu = i_rs1 - op_b;
			ALU_AND: alu = i_rs1 & op_b;
			ALU_OR: alu = i_rs1 | op_b;
			ALU_XOR: alu = i_rs1 ^ op_b;
			ALU_SLT: alu = {{(XLEN-1){1'b0}}, $signed(i_rs1) < $signed(op_b)};
			default: alu = op_b;
		endcase
	end

	// JAL writes its link address
	assign result = (i_kind == KIND_JAL) ? i_pc + XLEN'(4) : alu;

	// ====================
	// Branch resolution

	assign taken = (i_kind == KIND_JAL) ||
		((i_kind == KIND_BRANCH) && ((i_rs1 == i_rs2) != i_branch_ne));

	// Instruction behind a taken branch is already on the wrong path
	assign in_valid = i_valid && !o_redirect;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_valid <= 1'b0;
			o_redirect <= 1'b0;
		end else if (!i_stall) begin
			o_valid <= in_valid;
			o_redirect <= in_valid && taken;
		end else begin
			o_redirect <= 1'b0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_stall) begin
			o_rd_idx <= i_rd_idx;
			o_result <= result;
			o_mem_read <= i_mem_read;
			o_mem_write <= i_mem_write;
			o_store_data <= i_rs2;
			o_target <= i_pc + i_imm;
		end
	end

endmodule

`default_nettype wire

// File: src/cpu_memory.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_memory (
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_valid,
	input  logic [cpu_pipe_pkg::REG_INDEX_WIDTH-1:0] i_rd_idx,
	input  logic [cpu_isa_pkg::XLEN-1:0] i_result,
	input  logic i_mem_read,
	input  logic i_mem_write,
	input  logic [cpu_isa_pkg::XLEN-1:0] i_store_data,
	input  logic [cpu_isa_pkg::XLEN-1:0] i_dbus_dat_i,
	input  logic i_dbus_ack,
	output logic o_dbus_cyc,
	output logic o_dbus_stb,
	output logic o_dbus_we,
	output logic [cpu_isa_pkg::XLEN-1:0] o_dbus_adr,
	output logic [cpu_isa_pkg::XLEN-1:0] o_dbus_dat_o,
	output logic o_stall,
	output logic o_valid,
	output logic [cpu_pipe_pkg::REG_INDEX_WIDTH-1:0] o_rd_idx,
	output logic [cpu_isa_pkg::XLEN-1:0] o_value
);

	logic request;
	logic done;
	logic ack_last;

	// ====================
	// Data bus master

	assign request = i_valid && (i_mem_read || i_mem_write);

	// Bus goes idle for one cycle after every ack
	assign o_dbus_cyc = request && !ack_last;
	assign o_dbus_stb = o_dbus_cyc;
	assign o_dbus_we = i_mem_write;
	assign o_dbus_adr = i_result;
	assign o_dbus_dat_o = i_store_data;

	assign done = o_dbus_cyc && i_dbus_ack;
	assign o_stall = request && !done;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			ack_last <= 1'b0;
		end else begin
			ack_last <= done;
		end
	end

	// ====================
	// Memory stage register

	// A bubble goes forward while the access is outstanding
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid && !o_stall;
		end
	end

	always_ff @(posedge i_clock) begin
		if (!o_stall) begin
			o_rd_idx <= i_rd_idx;
			o_value <= i_mem_read ? i_dbus_dat_i : i_result;
		end
	end

endmodule

`default_nettype wire

// File: src/cpu_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_writeback (
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_valid,
	input  logic [cpu_pipe_pkg::REG_INDEX_WIDTH-1:0] i_rd_idx,
	input  logic [cpu_isa_pkg::XLEN-1:0] i_value,
	output logic o_wb_valid,
	output logic [cpu_pipe_pkg::REG_INDEX_WIDTH-1:0] o_wb_rd,
	output logic [cpu_isa_pkg::XLEN-1:0] o_wb_value,
	output logic [cpu_isa_pkg::XLEN-1:0] o_retire_count
);
	import cpu_isa_pkg::*;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_wb_valid <= 1'b0;
			o_retire_count <= '0;
		end else begin
			o_wb_valid <= i_valid;
			// Each instruction spends exactly one cycle here
			if (o_wb_valid) begin
				o_retire_count <= o_retire_count + XLEN'(1);
			end
		end
	end

	always_ff @(posedge i_clock) begin
		o_wb_rd <= i_rd_idx;
		o_wb_value <= i_value;
	end

endmodule

`default_nettype wire

// File: src/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
	input  logic i_clock,
	input  logic i_reset,
	output logic o_ibus_cyc,
	output logic o_ibus_stb,
	output logic [cpu_isa_pkg::XLEN-1:0] o_ibus_adr,
	input  logic [cpu_isa_pkg::XLEN-1:0] i_ibus_dat,
	input  logic i_ibus_ack,
	output logic o_dbus_cyc,
	output logic o_dbus_stb,
	output logic o_dbus_we,
	output logic [cpu_isa_pkg::XLEN-1:0] o_dbus_adr,
	output logic [cpu_isa_pkg::XLEN-1:0] o_dbus_dat_o,
	input  logic [cpu_isa_pkg::XLEN-1:0] i_dbus_dat_i,
	input  logic i_dbus_ack,
	output logic o_fault,
	output logic [cpu_isa_pkg::XLEN-1:0] o_retire_count
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	logic mem_stall, load_use_stall;
	logic ex_redirect;
	logic [XLEN-1:0] ex_target;

	logic fe_valid;
	logic [XLEN-1:0] fe_instruction, fe_pc;

	logic dec_valid, dec_use_imm, dec_branch_ne, dec_mem_read, dec_mem_write;
	logic [XLEN-1:0] dec_pc, dec_imm;
	logic [REG_INDEX_WIDTH-1:0] dec_rs1_idx, dec_rs2_idx, dec_rd_idx;
	op_kind_t dec_kind;
	alu_op_t dec_alu_op;

	logic [XLEN-1:0] rs1, rs2;

	logic ex_valid, ex_mem_read, ex_mem_write;
	logic [REG_INDEX_WIDTH-1:0] ex_rd;
	logic [XLEN-1:0] ex_result, ex_store_data;

	logic mem_valid;
	logic [REG_INDEX_WIDTH-1:0] mem_rd;
	logic [XLEN-1:0] mem_value;

	logic wb_valid;
	logic [REG_INDEX_WIDTH-1:0] wb_rd;
	logic [XLEN-1:0] wb_value;

	// ====================
	// Front end

	// A fault holds fetch for good
	cpu_fetch fetch_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_stall(mem_stall || load_use_stall || o_fault),
		.i_redirect(ex_redirect),
		.i_target(ex_target),
		.i_ibus_dat(i_ibus_dat),
		.i_ibus_ack(i_ibus_ack),
		.o_ibus_cyc(o_ibus_cyc),
		.o_ibus_stb(o_ibus_stb),
		.o_ibus_adr(o_ibus_adr),
		.o_valid(fe_valid),
		.o_instruction(fe_instruction),
		.o_pc(fe_pc)
	);

	cpu_decode decode_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_stall(mem_stall || load_use_stall),
		.i_flush(ex_redirect),
		.i_valid(fe_valid),
		.i_instruction(fe_instruction),
		.i_pc(fe_pc),
		.o_valid(dec_valid),
		.o_pc(dec_pc),
		.o_rs1_idx(dec_rs1_idx),
		.o_rs2_idx(dec_rs2_idx),
		.o_rd_idx(dec_rd_idx),
		.o_imm(dec_imm),
		.o_kind(dec_kind),
		.o_alu_op(dec_alu_op),
		.o_use_imm(dec_use_imm),
		.o_branch_ne(dec_branch_ne),
		.o_mem_read(dec_mem_read),
		.o_mem_write(dec_mem_write),
		.o_fault(o_fault)
	);

	cpu_operands operands_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rs1_idx(dec_rs1_idx),
		.i_rs2_idx(dec_rs2_idx),
		.i_ex_valid(ex_valid),
		.i_ex_rd(ex_rd),
		.i_ex_value(ex_result),
		.i_ex_load(ex_mem_read),
		.i_mem_valid(mem_valid),
		.i_mem_rd(mem_rd),
		.i_mem_value(mem_value),
		.i_wb_valid(wb_valid),
		.i_wb_rd(wb_rd),
		.i_wb_value(wb_value),
		.o_rs1(rs1),
		.o_rs2(rs2),
		.o_load_use_stall(load_use_stall)
	);

	// ====================
	// Back end

	// Load-use inserts a bubble into execute
	cpu_execute execute_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_stall(mem_stall),
		.i_valid(dec_valid && !load_use_stall),
		.i_pc(dec_pc),
		.i_rd_idx(dec_rd_idx),
		.i_imm(dec_imm),
		.i_kind(dec_kind),
		.i_alu_op(dec_alu_op),
		.i_use_imm(dec_use_imm),
		.i_branch_ne(dec_branch_ne),
		.i_mem_read(dec_mem_read),
		.i_mem_write(dec_mem_write),
		.i_rs1(rs1),
		.i_rs2(rs2),
		.o_valid(ex_valid),
		.o_rd_idx(ex_rd),
		.o_result(ex_result),
		.o_mem_read(ex_mem_read),
		.o_mem_write(ex_mem_write),
		.o_store_data(ex_store_data),
		.o_redirect(ex_redirect),
		.o_target(ex_target)
	);

	cpu_memory memory_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(ex_valid),
		.i_rd_idx(ex_rd),
		.i_result(ex_result),
		.i_mem_read(ex_mem_read),
		.i_mem_write(ex_mem_write),
		.i_store_data(ex_store_data),
		.i_dbus_dat_i(i_dbus_dat_i),
		.i_dbus_ack(i_dbus_ack),
		.o_dbus_cyc(o_dbus_cyc),
		.o_dbus_stb(o_dbus_stb),
		.o_dbus_we(o_dbus_we),
		.o_dbus_adr(o_dbus_adr),
		.o_dbus_dat_o(o_dbus_dat_o),
		.o_stall(mem_stall),
		.o_valid(mem_valid),
		.o_rd_idx(mem_rd),
		.o_value(mem_value)
	);

	cpu_writeback writeback_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(mem_valid),
		.i_rd_idx(mem_rd),
		.i_value(mem_value),
		.o_wb_valid(wb_valid),
		.o_wb_rd(wb_rd),
		.o_wb_value(wb_value),
		.o_retire_count(o_retire_count)
	);

endmodule

`default_nettype wire

// File: sim/tb_cpu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_assertions (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire logic i_ibus_cyc,
	input wire logic i_ibus_stb,
	input wire logic [31:0] i_ibus_adr,
	input wire logic i_ibus_ack,
	input wire logic i_dbus_cyc,
	input wire logic i_dbus_stb,
	input wire logic i_dbus_we,
	input wire logic [31:0] i_dbus_adr,
	input wire logic [31:0] i_dbus_dat,
	input wire logic i_dbus_ack
);

	// ====================
	// Reset and strobe rules

	assert property (@(posedge i_clock) $past(i_reset) |-> !i_ibus_cyc && !i_dbus_cyc)
		else $error("bus cycle active during or right after reset");

	assert property (@(posedge i_clock) disable iff (i_reset) i_ibus_stb |-> i_ibus_cyc)
		else $error("instruction bus stb without cyc");

	assert property (@(posedge i_clock) disable iff (i_reset) i_dbus_stb |-> i_dbus_cyc)
		else $error("data bus stb without cyc");

	// ====================
	// Hold until ack

	assert property (@(posedge i_clock) disable iff (i_reset)
		(i_ibus_stb && !i_ibus_ack) |=> i_ibus_stb && $stable(i_ibus_adr))
		else $error("instruction bus request changed before ack");

	assert property (@(posedge i_clock) disable iff (i_reset)
		(i_dbus_stb && !i_dbus_ack) |=> i_dbus_stb && $stable(i_dbus_adr) &&
		$stable(i_dbus_we) && $stable(i_dbus_dat))
		else $error("data bus request changed before ack");

	assert property (@(posedge i_clock) disable iff (i_reset) i_ibus_ack |=> !i_ibus_cyc)
		else $error("instruction bus cyc held after ack");

	assert property (@(posedge i_clock) disable iff (i_reset) i_dbus_ack |=> !i_dbus_cyc)
		else $error("data bus cyc held after ack");

endmodule

bind cpu_top tb_cpu_assertions assertions_inst (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_ibus_cyc(o_ibus_cyc),
	.i_ibus_stb(o_ibus_stb),
	.i_ibus_adr(o_ibus_adr),
	.i_ibus_ack(i_ibus_ack),
	.i_dbus_cyc(o_dbus_cyc),
	.i_dbus_stb(o_dbus_stb),
	.i_dbus_we(o_dbus_we),
	.i_dbus_adr(o_dbus_adr),
	.i_dbus_dat(o_dbus_dat_o),
	.i_dbus_ack(i_dbus_ack)
);

`default_nettype wire

// File: sim/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
	import cpu_isa_pkg::*;

	localparam int CLOCK_PERIOD = 4;

	logic i_clock;
	logic i_reset;
	logic o_ibus_cyc, o_ibus_stb;
	logic [XLEN-1:0] o_ibus_adr;
	logic [XLEN-1:0] i_ibus_dat;
	logic i_ibus_ack;
	logic o_dbus_cyc, o_dbus_stb, o_dbus_we;
	logic [XLEN-1:0] o_dbus_adr, o_dbus_dat_o;
	logic [XLEN-1:0] i_dbus_dat_i;
	logic i_dbus_ack;
	logic o_fault;
	logic [XLEN-1:0] o_retire_count;

	logic [XLEN-1:0] rom [0:255];
	logic [XLEN-1:0] ram [0:63];
	logic [XLEN-1:0] val [0:31];
	logic [XLEN-1:0] exp_adr [$];
	logic [XLEN-1:0] exp_dat [$];
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] jal_pc;
	logic [XLEN-1:0] loop_pc;
	integer seed;
	int ibus_wait, dbus_wait;
	int executed;
	int store_idx;
	int max_cycles;
	logic program_ready;

	cpu_top cpu_top_inst (.*);

	always #(CLOCK_PERIOD / 2) i_clock = ~i_clock;

	// ====================
	// Failure reporting

	task automatic abort_run();
		$display("Errors found");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic report_mismatch(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		abort_run();
	endtask

	// ====================
	// Instruction encoders

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OP_REG};
	endfunction

	function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [11:0] imm,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, F3_W, imm[4:0], OP_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
	endfunction

	// Initial RAM contents, every address bit matters
	function automatic logic [31:0] fill_word(input int idx);
		return 32'h1357_0000 + 32'(idx) * 32'h0001_0203;
	endfunction

	// Runs is how often the word executes, zero on a skipped path
	task automatic emit(input logic [31:0] word, input int runs);
		rom[pc[9:2]] = word;
		pc = pc + 4;
		executed = executed + runs;
	endtask

	task automatic emit_store(input logic [4:0] rs2, input logic [11:0] adr,
		input logic [31:0] value);
		emit(enc_s(adr, rs2, 5'd0), 1);
		exp_adr.push_back(32'(adr));
		exp_dat.push_back(value);
	endtask

	// ====================
	// Test program

	task automatic build_program();
		pc = RESET_PC;
		executed = 0;
		val[1] = 5;
		val[2] = val[1] - 3;
		val[3] = 32'h12345 << 12;
		val[4] = val[3] + val[1];
		val[5] = val[4] - val[2];
		val[6] = val[5] & val[1];
		val[7] = val[6] | val[3];
		val[8] = val[7] ^ val[2];
		val[9] = ($signed(val[2]) < $signed(val[1])) ? 1 : 0;
		val[10] = 32'hFFFF_FFFF;
		val[11] = ($signed(val[10]) < $signed(val[9])) ? 1 : 0;
		val[12] = val[8] ^ 32'h0FF;
		val[13] = val[6] | 32'h070;
		val[14] = val[4] & 32'h00F;
		val[15] = ($signed(val[10]) < 0) ? 1 : 0;

		// Dependent chain, each result feeds the next one
		emit(enc_i(OP_IMM, 12'd5, 5'd0, F3_ADD, 5'd1), 1);
		emit(enc_i(OP_IMM, -12'sd3, 5'd1, F3_ADD, 5'd2), 1);
		emit({20'h12345, 5'd3, OP_LUI}, 1);
		emit(enc_r(7'd0, 5'd1, 5'd3, F3_ADD, 5'd4), 1);
		emit(enc_r(F7_SUB, 5'd2, 5'd4, F3_ADD, 5'd5), 1);
		emit(enc_r(7'd0, 5'd1, 5'd5, F3_AND, 5'd6), 1);
		emit(enc_r(7'd0, 5'd3, 5'd6, F3_OR, 5'd7), 1);
		emit(enc_r(7'd0, 5'd2, 5'd7, F3_XOR, 5'd8), 1);
		emit(enc_r(7'd0, 5'd1, 5'd2, F3_SLT, 5'd9), 1);
		emit(enc_i(OP_IMM, 12'hFFF, 5'd0, F3_ADD, 5'd10), 1);
		emit(enc_r(7'd0, 5'd9, 5'd10, F3_SLT, 5'd11), 1);
		emit(enc_i(OP_IMM, 12'h0FF, 5'd8, F3_XOR, 5'd12), 1);
		emit(enc_i(OP_IMM, 12'h070, 5'd6, F3_OR, 5'd13), 1);
		emit(enc_i(OP_IMM, 12'h00F, 5'd4, F3_AND, 5'd14), 1);
		emit(enc_i(OP_IMM, 12'h000, 5'd10, F3_SLT, 5'd15), 1);
		for (int r = 1; r <= 15; r++) begin
			emit_store(5'(r), 12'(32'h80 + 4 * (r - 1)), val[r]);
		end

		// Load-use pair
		emit(enc_i(OP_LOAD, 12'd8, 5'd0, F3_W, 5'd16), 1);
		emit(enc_r(7'd0, 5'd1, 5'd16, F3_ADD, 5'd17), 1);
		emit_store(5'd17, 12'h0C0, fill_word(2) + val[1]);

		// Counted loop, four passes
		emit(enc_i(OP_IMM, 12'd0, 5'd0, F3_ADD, 5'd18), 1);
		emit(enc_i(OP_IMM, 12'd4, 5'd0, F3_ADD, 5'd19), 1);
		loop_pc = pc;
		emit(enc_i(OP_IMM, 12'd1, 5'd18, F3_ADD, 5'd18), 4);
		emit(enc_b(13'(loop_pc - pc), 5'd19, 5'd18, F3_BNE), 4);
		emit_store(5'd18, 12'h0C4, 32'd4);

		// Taken BEQ and JAL skip two stores each
		emit(enc_b(13'd12, 5'd0, 5'd0, F3_BEQ), 1);
		emit(enc_s(12'h0F0, 5'd1, 5'd0), 0);
		emit(enc_s(12'h0F4, 5'd1, 5'd0), 0);
		jal_pc = pc;
		emit(enc_j(21'd12, 5'd20), 1);
		emit(enc_s(12'h0F8, 5'd1, 5'd0), 0);
		emit(enc_s(12'h0FC, 5'd1, 5'd0), 0);
		emit_store(5'd20, 12'h0C8, jal_pc + 4);

		// Illegal word ends the program
		emit(32'd0, 0);
		max_cycles = 20 + 10 * executed;
	endtask

	// ====================
	// Bus slaves

	always @(negedge i_clock) begin
		if (i_reset) begin
			i_ibus_ack <= 1'b0;
			ibus_wait <= $random(seed) & 3;
		end else if (i_ibus_ack) begin
			i_ibus_ack <= 1'b0;
			ibus_wait <= $random(seed) & 3;
		end else if (o_ibus_cyc && o_ibus_stb) begin
			if (ibus_wait == 0) begin
				i_ibus_ack <= 1'b1;
				i_ibus_dat <= rom[o_ibus_adr[9:2]];
			end else begin
				ibus_wait <= ibus_wait - 1;
			end
		end
	end

	always @(negedge i_clock) begin
		if (i_reset) begin
			i_dbus_ack <= 1'b0;
			dbus_wait <= $random(seed) & 3;
		end else if (i_dbus_ack) begin
			i_dbus_ack <= 1'b0;
			dbus_wait <= $random(seed) & 3;
		end else if (o_dbus_cyc && o_dbus_stb) begin
			if (dbus_wait == 0) begin
				i_dbus_ack <= 1'b1;
				i_dbus_dat_i <= ram[o_dbus_adr[7:2]];
				if (o_dbus_we) begin
					ram[o_dbus_adr[7:2]] <= o_dbus_dat_o;
				end
			end else begin
				dbus_wait <= dbus_wait - 1;
			end
		end
	end

	// Each acked store is compared with the next expected one
	always @(posedge i_clock) begin
		if (!i_reset && o_dbus_cyc && o_dbus_stb && o_dbus_we && i_dbus_ack) begin
			assert (store_idx < exp_adr.size())
				else report_mismatch($sformatf("unexpected store to %h", o_dbus_adr));
			assert (o_dbus_adr == exp_adr[store_idx])
				else report_mismatch($sformatf("store %0d address %h, expected %h",
					store_idx, o_dbus_adr, exp_adr[store_idx]));
			assert (o_dbus_dat_o == exp_dat[store_idx])
				else report_mismatch($sformatf("store %0d data %h, expected %h",
					store_idx, o_dbus_dat_o, exp_dat[store_idx]));
			store_idx <= store_idx + 1;
		end
	end

	initial begin
		wait (program_ready);
		#(40 * max_cycles * CLOCK_PERIOD);
		$display("Timeout: the program did not finish in time");
		abort_run();
	end

	// ====================
	// Main sequence

	initial begin
		seed = 61951;
		i_clock = 1'b0;
		i_reset = 1'b1;
		i_ibus_ack = 1'b0;
		i_ibus_dat = '0;
		i_dbus_ack = 1'b0;
		i_dbus_dat_i = '0;
		store_idx = 0;
		program_ready = 1'b0;
		for (int i = 0; i < 256; i++) begin
			rom[i] = '0;
		end
		for (int i = 0; i < 64; i++) begin
			ram[i] = fill_word(i);
		end
		build_program();
		program_ready = 1'b1;

		repeat (5) @(posedge i_clock);
		@(negedge i_clock);
		i_reset = 1'b0;

		wait (o_retire_count == 32'(executed));
		// Let anything left over show up
		repeat (30) @(posedge i_clock);
		assert (o_fault)
			else report_mismatch("fault flag not raised on the illegal word");
		assert (o_retire_count == 32'(executed))
			else report_mismatch($sformatf("retire count %0d, expected %0d",
				o_retire_count, executed));
		assert (store_idx == exp_adr.size())
			else report_mismatch($sformatf("%0d stores seen, expected %0d",
				store_idx, exp_adr.size()));
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
src/cpu_isa_pkg.sv
src/cpu_pipe_pkg.sv
src/cpu_fetch.sv
src/cpu_decode.sv
src/cpu_operands.sv
src/cpu_execute.sv
src/cpu_memory.sv
src/cpu_writeback.sv
src/cpu_top.sv
sim/tb_cpu_assertions.sv
sim/tb_cpu.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the CPU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_cpu \
	-f compile.f \
	-o tb_cpu

# Exit status of the simulation decides pass or fail
./obj_dir/tb_cpu
